//--- hw/gamePkg.sv
`default_nettype none

package gamePkg;

    // pixel coordinate, wide enough for the full VGA counter range
    typedef logic [10:0] coord_t;

    typedef logic [7:0] rgb_t;

    // visible screen
    localparam coord_t SCREEN_W = 11'd640;
    localparam coord_t SCREEN_H = 11'd480;

    // player ship, square sprite
    localparam coord_t SHIP_SIZE = 11'd32;

    // bottom centre of the screen
    localparam coord_t SHIP_START_X = 11'd304;
    localparam coord_t SHIP_START_Y = 11'd440;

    localparam rgb_t SHIP_RGB = 8'h1F;

    // missile rectangle
    localparam coord_t MISSILE_W = 11'd2;
    localparam coord_t MISSILE_H = 11'd8;

    localparam rgb_t MISSILE_RGB = 8'hFC;

endpackage

`default_nettype wire

//--- hw/keyPkg.sv
`default_nettype none

package keyPkg;

    // extended scan codes carry the E0 prefix in bit 8
    typedef logic [8:0] keyCode_t;

    localparam keyCode_t KEY_UP    = 9'h06C;
    localparam keyCode_t KEY_DOWN  = 9'h075;
    localparam keyCode_t KEY_LEFT  = 9'h073;
    localparam keyCode_t KEY_RIGHT = 9'h14A;

    // keypad enter
    localparam keyCode_t KEY_FIRE  = 9'h15A;

endpackage

`default_nettype wire

//--- hw/keyStateIf.sv
`default_nettype none

interface keyStateIf;
    logic up;
    logic down;
    logic left;
    logic right;
    logic fire;

    modport decoder (output up, down, left, right, fire);
    modport consumer (input up, down, left, right, fire);
endinterface

`default_nettype wire

//--- hw/keyDecoder.sv
`default_nettype none

module keyDecoder (
    input  logic             clk,
    input  logic             reset,
    input  logic             keyReq,
    input  keyPkg::keyCode_t keyCode,
    input  logic             keyBreak,
    output logic             keyAck,
    keyStateIf.decoder       keys
);
    import keyPkg::*;

    typedef enum logic {PH_IDLE, PH_ACK} phase_t;

    phase_t phase;
    logic   pressed;

    // make sets the flag, break clears it
    assign pressed = !keyBreak;
    assign keyAck = (phase == PH_ACK);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase      <= PH_IDLE;
            keys.up    <= 1'b0;
            keys.down  <= 1'b0;
            keys.left  <= 1'b0;
            keys.right <= 1'b0;
            keys.fire  <= 1'b0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (keyReq) begin
                        phase <= PH_ACK;
                        // unknown codes are acked and dropped
                        case (keyCode)
                            KEY_UP:    keys.up    <= pressed;
                            KEY_DOWN:  keys.down  <= pressed;
                            KEY_LEFT:  keys.left  <= pressed;
                            KEY_RIGHT: keys.right <= pressed;
                            KEY_FIRE:  keys.fire  <= pressed;
                            default: ;
                        endcase
                    end
                end
                PH_ACK: begin
                    if (!keyReq) begin
                        phase <= PH_IDLE;
                    end
                end
            endcase
        end
    end

    ackFollowsReq: assert property (@(posedge clk) disable iff (reset)
        $rose(keyAck) |-> $past(keyReq));

endmodule

`default_nettype wire

//--- hw/playerMove.sv
`default_nettype none

module playerMove #(
    parameter int MOVE_STEP = 4
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           frameTick,
    keyStateIf.consumer    keys,
    output gamePkg::coord_t shipX,
    output gamePkg::coord_t shipY
);
    import gamePkg::*;

    localparam coord_t STEP  = coord_t'(MOVE_STEP);
    localparam coord_t MAX_X = SCREEN_W - SHIP_SIZE;
    localparam coord_t MAX_Y = SCREEN_H - SHIP_SIZE;

    // one axis, saturating at 0 and maxPos, opposing keys cancel
    function automatic coord_t stepAxis(coord_t pos, logic dec, logic inc, coord_t maxPos);
        coord_t result;
        result = pos;
        if (inc && !dec) begin
            result = (pos > maxPos - STEP) ? maxPos : pos + STEP;
        end else if (dec && !inc) begin
            result = (pos < STEP) ? '0 : pos - STEP;
        end
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            shipX <= SHIP_START_X;
            shipY <= SHIP_START_Y;
        end else if (frameTick) begin
            shipX <= stepAxis(shipX, keys.left, keys.right, MAX_X);
            // screen Y grows downwards
            shipY <= stepAxis(shipY, keys.up, keys.down, MAX_Y);
        end
    end

    shipOnScreen: assert property (@(posedge clk) disable iff (reset)
        (shipX <= MAX_X) && (shipY <= MAX_Y));

endmodule

`default_nettype wire

//--- hw/spriteDraw.sv
`default_nettype none

module spriteDraw (
    input  logic            clk,
    input  logic            reset,
    input  gamePkg::coord_t pixelX,
    input  gamePkg::coord_t pixelY,
    input  gamePkg::coord_t shipX,
    input  gamePkg::coord_t shipY,
    input  logic            faded,
    output logic            playerDR,
    output gamePkg::rgb_t   playerRGB
);
    import gamePkg::*;

    coord_t offsetX;
    coord_t offsetY;
    logic   insideSquare;
    logic   shapeHit;

    assign offsetX = pixelX - shipX;
    assign offsetY = pixelY - shipY;

    assign insideSquare = (pixelX >= shipX) && (pixelX < shipX + SHIP_SIZE) &&
                          (pixelY >= shipY) && (pixelY < shipY + SHIP_SIZE);

    // nose column in the middle, wings across the lower half
    assign shapeHit = ((offsetX >= 11'd12) && (offsetX <= 11'd19)) || (offsetY >= 11'd16);

    always_ff @(posedge clk) begin
        if (reset) begin
            playerDR  <= 1'b0;
            playerRGB <= '0;
        end else begin
            playerDR  <= insideSquare && shapeHit;
            // a faded ship still claims its pixels, just black
            playerRGB <= (insideSquare && shapeHit && !faded) ? SHIP_RGB : '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/playerLives.sv
`default_nettype none

module playerLives #(
    parameter int LIVES       = 3,
    parameter int FADE_FRAMES = 10
) (
    input  logic clk,
    input  logic reset,
    input  logic frameTick,
    input  logic playerHit,
    output logic faded,
    output logic playerDead
);
    localparam int LIFE_W = $clog2(LIVES + 1);
    localparam int FADE_W = $clog2(FADE_FRAMES + 1);

    logic [LIFE_W-1:0] lifeCount;
    logic [FADE_W-1:0] fadeCount;
    logic              hitTaken;

    // hits during the fade or after death cost nothing
    assign hitTaken = playerHit && !faded && !playerDead && (lifeCount != '0);
    assign faded = (fadeCount != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            lifeCount  <= LIFE_W'(LIVES);
            fadeCount  <= '0;
            playerDead <= 1'b0;
        end else begin
            if (hitTaken) begin
                lifeCount <= lifeCount - 1'b1;
                fadeCount <= FADE_W'(FADE_FRAMES);
            end else if (frameTick && faded) begin
                fadeCount <= fadeCount - 1'b1;
            end
            // sticky until reset
            if (lifeCount == '0) begin
                playerDead <= 1'b1;
            end
        end
    end

    deadMeansNoLives: assert property (@(posedge clk) disable iff (reset)
        playerDead |-> (lifeCount == '0));

endmodule

`default_nettype wire

//--- hw/missileUnit.sv
`default_nettype none

module missileUnit #(
    parameter int MISSILE_STEP    = 8,
    parameter int COOLDOWN_FRAMES = 6
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            frameTick,
    keyStateIf.consumer     keys,
    input  logic            faded,
    input  logic            playerDead,
    input  gamePkg::coord_t shipX,
    input  gamePkg::coord_t shipY,
    input  logic            missileHit,
    input  gamePkg::coord_t pixelX,
    input  gamePkg::coord_t pixelY,
    output logic            missileDR,
    output gamePkg::rgb_t   missileRGB
);
    import gamePkg::*;

    localparam int     CD_W        = $clog2(COOLDOWN_FRAMES + 1);
    localparam coord_t STEP        = coord_t'(MISSILE_STEP);
    localparam coord_t NOSE_OFFSET = (SHIP_SIZE - MISSILE_W) / 2;

    typedef enum logic {S_IDLE, S_FLYING} missileState_t;

    missileState_t     state;
    coord_t            missileX;
    coord_t            missileY;
    logic [CD_W-1:0]   cooldown;
    logic              launch;
    logic              insideMissile;

    // no room above the ship when it sits at the very top
    assign launch = frameTick && keys.fire && (cooldown == '0) && (state == S_IDLE) &&
                    !faded && !playerDead && (shipY >= MISSILE_H);

    assign insideMissile = (state == S_FLYING) &&
                           (pixelX >= missileX) && (pixelX < missileX + MISSILE_W) &&
                           (pixelY >= missileY) && (pixelY < missileY + MISSILE_H);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            cooldown <= '0;
        end else begin
            if (launch) begin
                state    <= S_FLYING;
                cooldown <= CD_W'(COOLDOWN_FRAMES);
            end else begin
                if (frameTick && (cooldown != '0)) begin
                    cooldown <= cooldown - 1'b1;
                end
                // top of screen reached
                if (missileHit || (frameTick && (state == S_FLYING) && (missileY < STEP))) begin
                    state <= S_IDLE;
                end
            end
        end
    end

    // loaded at launch and raised once per frame
    always_ff @(posedge clk) begin
        if (launch) begin
            missileX <= shipX + NOSE_OFFSET;
            missileY <= shipY - MISSILE_H;
        end else if (frameTick && (state == S_FLYING)) begin
            missileY <= missileY - STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            missileDR  <= 1'b0;
            missileRGB <= '0;
        end else begin
            missileDR  <= insideMissile;
            missileRGB <= insideMissile ? MISSILE_RGB : '0;
        end
    end

    launchFromZero: assert property (@(posedge clk) disable iff (reset)
        $rose(state == S_FLYING) |-> $past(cooldown == '0) && (cooldown == CD_W'(COOLDOWN_FRAMES)));

endmodule

`default_nettype wire

//--- hw/playerTop.sv
`default_nettype none

module playerTop #(
    parameter int MOVE_STEP       = 4,
    parameter int MISSILE_STEP    = 8,
    parameter int COOLDOWN_FRAMES = 6,
    parameter int LIVES           = 3,
    parameter int FADE_FRAMES     = 10
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             enable,
    input  logic             keyReq,
    input  keyPkg::keyCode_t keyCode,
    input  logic             keyBreak,
    output logic             keyAck,
    input  logic             startOfFrame,
    input  gamePkg::coord_t  pixelX,
    input  gamePkg::coord_t  pixelY,
    input  logic             playerHit,
    input  logic             missileHit,
    output logic             playerDR,
    output gamePkg::rgb_t    playerRGB,
    output logic             missileDR,
    output gamePkg::rgb_t    missileRGB,
    output logic             playerDead
);
    gamePkg::coord_t shipX;
    gamePkg::coord_t shipY;
    logic            frameTick;
    logic            faded;

    // game logic advances only on enabled frames
    assign frameTick = startOfFrame && enable;

    keyStateIf keys ();

    keyDecoder keyDecoder_i (
        .clk(clk), .reset(reset), .keyReq(keyReq), .keyCode(keyCode),
        .keyBreak(keyBreak), .keyAck(keyAck), .keys(keys.decoder)
    );

    playerMove #(.MOVE_STEP(MOVE_STEP)) playerMove_i (
        .clk(clk), .reset(reset), .frameTick(frameTick), .keys(keys.consumer),
        .shipX(shipX), .shipY(shipY)
    );

    spriteDraw spriteDraw_i (
        .clk(clk), .reset(reset), .pixelX(pixelX), .pixelY(pixelY),
        .shipX(shipX), .shipY(shipY), .faded(faded),
        .playerDR(playerDR), .playerRGB(playerRGB)
    );

    playerLives #(.LIVES(LIVES), .FADE_FRAMES(FADE_FRAMES)) playerLives_i (
        .clk(clk), .reset(reset), .frameTick(frameTick), .playerHit(playerHit),
        .faded(faded), .playerDead(playerDead)
    );

    missileUnit #(.MISSILE_STEP(MISSILE_STEP), .COOLDOWN_FRAMES(COOLDOWN_FRAMES)) missileUnit_i (
        .clk(clk), .reset(reset), .frameTick(frameTick), .keys(keys.consumer),
        .faded(faded), .playerDead(playerDead), .shipX(shipX), .shipY(shipY),
        .missileHit(missileHit), .pixelX(pixelX), .pixelY(pixelY),
        .missileDR(missileDR), .missileRGB(missileRGB)
    );

endmodule

`default_nettype wire

//--- verification/playerTb.sv
`default_nettype none

module playerTb;
    import gamePkg::*;
    import keyPkg::*;

    localparam int MOVE_STEP       = 4;
    localparam int MISSILE_STEP    = 8;
    localparam int COOLDOWN_FRAMES = 6;
    localparam int LIVES           = 3;
    localparam int FADE_FRAMES     = 10;

    localparam int SHIP_SPAN  = int'(SHIP_SIZE);
    localparam int MIS_WIDTH  = int'(MISSILE_W);
    localparam int MIS_HEIGHT = int'(MISSILE_H);
    localparam int LIMIT_X    = int'(SCREEN_W) - SHIP_SPAN;
    localparam int LIMIT_Y    = int'(SCREEN_H) - SHIP_SPAN;
    localparam int NUM_ROWS   = 73;

    typedef enum {OP_KEY, OP_TICK, OP_HIT, OP_PROBE, OP_RAND} op_t;

    // KEY code/break, TICK count/enable, HIT 0 player or 1 missile,
    // PROBE x/y, RAND 0 ship area or 1 missile area
    typedef struct {
        op_t op;
        int  a;
        int  b;
    } row_t;

    logic      clk = 1'b0;
    logic      reset;
    logic      enable;
    logic      keyReq;
    keyCode_t  keyCode;
    logic      keyBreak;
    logic      keyAck;
    logic      startOfFrame;
    coord_t    pixelX;
    coord_t    pixelY;
    logic      playerHit;
    logic      missileHit;
    logic      playerDR;
    rgb_t      playerRGB;
    logic      missileDR;
    rgb_t      missileRGB;
    logic      playerDead;

    row_t rows [NUM_ROWS];
    int   valueErrors = 0;
    int   protocolErrors = 0;
    int   cycleCount = 0;
    int   cycleLimit = 0;
    int   totalCycles;

    // reference model of the player block
    int expX;
    int expY;
    int misX;
    int misY;
    int cooldown;
    int fadeLeft;
    int lives;
    bit flying;
    bit heldUp;
    bit heldDown;
    bit heldLeft;
    bit heldRight;
    bit heldFire;

    playerTop #(
        .MOVE_STEP(MOVE_STEP), .MISSILE_STEP(MISSILE_STEP),
        .COOLDOWN_FRAMES(COOLDOWN_FRAMES), .LIVES(LIVES), .FADE_FRAMES(FADE_FRAMES)
    ) dut_i (
        .clk(clk), .reset(reset), .enable(enable), .keyReq(keyReq), .keyCode(keyCode),
        .keyBreak(keyBreak), .keyAck(keyAck), .startOfFrame(startOfFrame),
        .pixelX(pixelX), .pixelY(pixelY), .playerHit(playerHit), .missileHit(missileHit),
        .playerDR(playerDR), .playerRGB(playerRGB), .missileDR(missileDR),
        .missileRGB(missileRGB), .playerDead(playerDead)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount > cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic checkValue(string name, int expected, int actual);
        assert (expected == actual) else begin
            valueErrors++;
            $display("[ERROR] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    function automatic int rowCycles(row_t r);
        case (r.op)
            OP_KEY:  return 3;
            OP_TICK: return 2 * r.a;
            default: return 1;
        endcase
    endfunction

    function automatic int clampMove(int pos, bit dec, bit inc, int maxPos);
        if (inc && !dec) begin
            return (pos + MOVE_STEP > maxPos) ? maxPos : pos + MOVE_STEP;
        end
        if (dec && !inc) begin
            return (pos < MOVE_STEP) ? 0 : pos - MOVE_STEP;
        end
        return pos;
    endfunction

    // launch is decided on the state before the enabled frame
    function automatic void advanceModel();
        bit launch;
        launch = heldFire && cooldown == 0 && !flying && fadeLeft == 0 && lives > 0 &&
                 expY >= MIS_HEIGHT;
        if (fadeLeft > 0) begin
            fadeLeft--;
        end
        if (launch) begin
            flying = 1'b1;
            cooldown = COOLDOWN_FRAMES;
            misX = expX + (SHIP_SPAN - MIS_WIDTH) / 2;
            misY = expY - MIS_HEIGHT;
        end else begin
            if (cooldown > 0) begin
                cooldown--;
            end
            if (flying) begin
                flying = (misY >= MISSILE_STEP);
                misY -= MISSILE_STEP;
            end
        end
        expX = clampMove(expX, heldLeft, heldRight, LIMIT_X);
        expY = clampMove(expY, heldUp, heldDown, LIMIT_Y);
    endfunction

    task automatic sendKey(int code, int brk);
        int waited;
        keyReq = 1'b1;
        keyCode = keyCode_t'(code);
        keyBreak = brk[0];
        do begin
            @(posedge clk);
            #1;
        end while (!keyAck);
        keyReq = 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (keyAck && waited < 4);
        assert (!keyAck) else begin
            protocolErrors++;
            $display("keyAck stayed high after keyReq was dropped");
        end
        case (keyCode_t'(code))
            KEY_UP:    heldUp = !brk[0];
            KEY_DOWN:  heldDown = !brk[0];
            KEY_LEFT:  heldLeft = !brk[0];
            KEY_RIGHT: heldRight = !brk[0];
            KEY_FIRE:  heldFire = !brk[0];
            default: ;
        endcase
    endtask

    task automatic frameTicks(int count, bit en);
        repeat (count) begin
            startOfFrame = 1'b1;
            enable = en;
            @(posedge clk);
            #1;
            startOfFrame = 1'b0;
            enable = 1'b1;
            if (en) begin
                advanceModel();
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic pulseHit(bit onPlayer);
        playerHit = onPlayer;
        missileHit = !onPlayer;
        @(posedge clk);
        #1;
        playerHit = 1'b0;
        missileHit = 1'b0;
        if (!onPlayer) begin
            flying = 1'b0;
        end else if (fadeLeft == 0 && lives > 0) begin
            lives--;
            fadeLeft = FADE_FRAMES;
        end
    endtask

    task automatic probePixel(int x, int y);
        int ox;
        int oy;
        bit drawn;
        bit inMissile;
        ox = x - expX;
        oy = y - expY;
        drawn = ox >= 0 && ox < SHIP_SPAN && oy >= 0 && oy < SHIP_SPAN &&
                ((ox >= 12 && ox <= 19) || oy >= 16);
        inMissile = flying && x >= misX && x < misX + MIS_WIDTH &&
                    y >= misY && y < misY + MIS_HEIGHT;
        pixelX = coord_t'(x);
        pixelY = coord_t'(y);
        @(posedge clk);
        #1;
        checkValue("playerDR", drawn, playerDR);
        checkValue("playerRGB", (drawn && fadeLeft == 0) ? int'(SHIP_RGB) : 0, playerRGB);
        checkValue("missileDR", inMissile, missileDR);
        checkValue("missileRGB", inMissile ? int'(MISSILE_RGB) : 0, missileRGB);
        checkValue("playerDead", lives == 0, playerDead);
    endtask

    task automatic probeRandom(bit onMissile);
        int x;
        int y;
        if (onMissile) begin
            x = misX + int'($urandom % MIS_WIDTH);
            y = misY + int'($urandom % MIS_HEIGHT);
        end else begin
            x = expX + int'($urandom % SHIP_SPAN);
            y = expY + int'($urandom % SHIP_SPAN);
        end
        probePixel(x, y);
    endtask

    initial begin
        void'($urandom(27804));
        reset = 1'b1;
        enable = 1'b1;
        keyReq = 1'b0;
        keyCode = '0;
        keyBreak = 1'b0;
        startOfFrame = 1'b0;
        pixelX = '0;
        pixelY = '0;
        playerHit = 1'b0;
        missileHit = 1'b0;
        expX = int'(SHIP_START_X);
        expY = int'(SHIP_START_Y);
        misX = 0;
        misY = 0;
        cooldown = 0;
        fadeLeft = 0;
        lives = LIVES;
        flying = 1'b0;
        {heldUp, heldDown, heldLeft, heldRight, heldFire} = '0;

        rows = '{
            // nose, empty corners and wing at the start position
            '{OP_PROBE, 319, 440}, '{OP_PROBE, 304, 440}, '{OP_PROBE, 304, 460},
            '{OP_PROBE, 335, 440}, '{OP_RAND, 0, 0},
            // opposing keys cancel, release stops, unknown code ignored
            '{OP_KEY, KEY_RIGHT, 0}, '{OP_TICK, 3, 1}, '{OP_RAND, 0, 0},
            '{OP_KEY, KEY_LEFT, 0}, '{OP_TICK, 2, 1}, '{OP_KEY, KEY_RIGHT, 1},
            '{OP_TICK, 2, 1}, '{OP_KEY, KEY_LEFT, 1}, '{OP_KEY, 'h01C, 0},
            '{OP_KEY, KEY_RIGHT, 0}, '{OP_TICK, 3, 0}, '{OP_PROBE, 308, 456},
            // clamp at all four edges
            '{OP_TICK, 80, 1}, '{OP_PROBE, 639, 471}, '{OP_KEY, KEY_RIGHT, 1},
            '{OP_KEY, KEY_LEFT, 0}, '{OP_TICK, 160, 1}, '{OP_PROBE, 0, 440},
            '{OP_PROBE, 0, 471}, '{OP_KEY, KEY_LEFT, 1}, '{OP_KEY, KEY_UP, 0},
            '{OP_TICK, 115, 1}, '{OP_PROBE, 12, 0}, '{OP_KEY, KEY_UP, 1},
            '{OP_KEY, KEY_DOWN, 0}, '{OP_TICK, 115, 1}, '{OP_PROBE, 31, 479},
            '{OP_KEY, KEY_DOWN, 1},
            // launch, flight, cooldown, missile hit, leaving the screen
            '{OP_KEY, KEY_FIRE, 0}, '{OP_TICK, 1, 1}, '{OP_PROBE, 15, 440},
            '{OP_TICK, 1, 1}, '{OP_RAND, 1, 0}, '{OP_TICK, 3, 1}, '{OP_RAND, 1, 0},
            '{OP_HIT, 1, 0}, '{OP_RAND, 1, 0}, '{OP_TICK, 1, 1}, '{OP_PROBE, 15, 440},
            '{OP_TICK, 2, 1}, '{OP_RAND, 1, 0}, '{OP_TICK, 7, 1}, '{OP_RAND, 1, 0},
            '{OP_KEY, KEY_FIRE, 1}, '{OP_TICK, 60, 1}, '{OP_RAND, 1, 0},
            // fade after a hit
            '{OP_HIT, 0, 0}, '{OP_RAND, 0, 0}, '{OP_KEY, KEY_FIRE, 0}, '{OP_TICK, 1, 1},
            '{OP_PROBE, 15, 440}, '{OP_HIT, 0, 0}, '{OP_TICK, 8, 1}, '{OP_RAND, 0, 0},
            '{OP_TICK, 1, 1}, '{OP_RAND, 0, 0}, '{OP_KEY, KEY_FIRE, 1},
            // remaining lives and death
            '{OP_HIT, 0, 0}, '{OP_TICK, 10, 1}, '{OP_HIT, 0, 0}, '{OP_RAND, 0, 0},
            '{OP_TICK, 12, 1}, '{OP_RAND, 0, 0}, '{OP_KEY, KEY_FIRE, 0},
            '{OP_TICK, 1, 1}, '{OP_PROBE, 15, 440}, '{OP_HIT, 0, 0}, '{OP_RAND, 0, 0}
        };

        totalCycles = 8;
        foreach (rows[i]) begin
            totalCycles += rowCycles(rows[i]);
        end
        cycleLimit = 2 * totalCycles + 200;

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        checkValue("keyAck", 0, keyAck);
        checkValue("playerDR", 0, playerDR);
        checkValue("playerRGB", 0, playerRGB);
        checkValue("missileDR", 0, missileDR);
        checkValue("missileRGB", 0, missileRGB);
        checkValue("playerDead", 0, playerDead);

        foreach (rows[i]) begin
            case (rows[i].op)
                OP_KEY:   sendKey(rows[i].a, rows[i].b);
                OP_TICK:  frameTicks(rows[i].a, rows[i].b != 0);
                OP_HIT:   pulseHit(rows[i].a == 0);
                OP_PROBE: probePixel(rows[i].a, rows[i].b);
                default:  probeRandom(rows[i].a == 1);
            endcase
        end

        $display("value errors: %0d, handshake errors: %0d", valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hw/gamePkg.sv
hw/keyPkg.sv
hw/keyStateIf.sv
hw/keyDecoder.sv
hw/playerMove.sv
hw/spriteDraw.sv
hw/playerLives.sv
hw/missileUnit.sv
hw/playerTop.sv
verification/playerTb.sv

//--- Makefile
TOP = playerTb

all: run

obj_dir/V$(TOP): compile.f hw/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
